/* src/fpu_pkg.sv */
package fpu_pkg;

    localparam int NUM_THREADS   = 4;
    localparam int WARP_BITS     = 2;
    localparam int RD_BITS       = 5;
    localparam int FIFO_DEPTH    = 4;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_BITS = FIFO_PTR_BITS + 1;

    localparam logic [31:0] CANON_NAN = 32'h7FC0_0000;

    // Sub-op codes carried in the frm field
    localparam logic [2:0] SEL_PLAIN = 3'd0;
    localparam logic [2:0] SEL_NEG   = 3'd1;
    localparam logic [2:0] SEL_XOR   = 3'd2;
    localparam logic [2:0] SEL_MIN   = 3'd0;
    localparam logic [2:0] SEL_MAX   = 3'd1;
    localparam logic [2:0] SEL_FLE   = 3'd0;
    localparam logic [2:0] SEL_FLT   = 3'd1;
    localparam logic [2:0] SEL_FEQ   = 3'd2;

    typedef enum logic [3:0] {
        SGNJ  = 4'd0,
        SGNJN = 4'd1,
        SGNJX = 4'd2,
        MIN   = 4'd3,
        MAX   = 4'd4,
        CMP   = 4'd5,
        CLASS = 4'd6,
        MVXW  = 4'd7,
        MVWX  = 4'd8
    } fpu_op_e;

    typedef enum logic [2:0] {
        OP_SGNJ   = 3'd0,
        OP_MINMAX = 3'd1,
        OP_CMP    = 3'd2,
        OP_CLASS  = 3'd3,
        OP_MOVE   = 3'd4
    } core_op_e;

    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } frm_e;

    typedef union packed {
        frm_e       rm;   // Rounding mode view
        logic [2:0] code; // Sub-op selector view
    } frm_sel_u;

    typedef logic [NUM_THREADS-1:0][31:0] lane_data_t;

    typedef struct packed {
        fpu_op_e              op;
        frm_sel_u             frm;
        logic [NUM_THREADS-1:0] tmask;
        lane_data_t           rs1_data;
        lane_data_t           rs2_data;
        logic [RD_BITS-1:0]   rd;
        logic                 wb;
        logic [WARP_BITS-1:0] warp_num;
    } fpu_req_t;

    typedef struct packed {
        core_op_e             core_op;
        logic                 op_mod;
        frm_sel_u             sel;
        lane_data_t           rs1_data;
        lane_data_t           rs2_data;
        logic [NUM_THREADS-1:0] tmask;
        logic [RD_BITS-1:0]   rd;
        logic                 wb;
        logic [WARP_BITS-1:0] warp_num;
    } fpu_exec_t;

    typedef struct packed {
        logic [NUM_THREADS-1:0] tmask;
        lane_data_t           data;
        logic [NUM_THREADS-1:0] nv;
        logic [RD_BITS-1:0]   rd;
        logic                 wb;
        logic [WARP_BITS-1:0] warp_num;
    } fpu_rsp_t;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        logic [WARP_BITS-1:0] warp_num;
        fflags_t              fflags;
    } fpu_csr_t;

endpackage

/* src/fpu_req_decode.sv */
`timescale 1ns/1ps

module fpu_req_decode import fpu_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  logic      req_valid_i,
    input  fpu_req_t  req_i,
    output logic      req_ready_o,

    output logic      exe_valid_o,
    output fpu_exec_t exe_o,
    input  logic      exe_ready_i
);

    fpu_exec_t exe_d;
    fpu_exec_t exe_q;
    logic      valid_q;

    assign req_ready_o = !valid_q || exe_ready_i;
    assign exe_valid_o = valid_q;
    assign exe_o       = exe_q;

    always_comb begin
        exe_d.core_op  = OP_SGNJ;
        exe_d.op_mod   = 1'b0;
        exe_d.sel      = req_i.frm;
        exe_d.rs1_data = req_i.rs1_data;
        exe_d.rs2_data = req_i.rs2_data;
        exe_d.tmask    = req_i.tmask;
        exe_d.rd       = req_i.rd;
        exe_d.wb       = req_i.wb;
        exe_d.warp_num = req_i.warp_num;
        case (req_i.op)
            SGNJ:  exe_d.sel.code = SEL_PLAIN;
            SGNJN: exe_d.sel.code = SEL_NEG;
            SGNJX: exe_d.sel.code = SEL_XOR;
            MIN: begin
                exe_d.core_op  = OP_MINMAX;
                exe_d.sel.code = SEL_MIN;
            end
            MAX: begin
                exe_d.core_op  = OP_MINMAX;
                exe_d.sel.code = SEL_MAX;
            end
            CMP:   exe_d.core_op = OP_CMP; // frm selects FLE/FLT/FEQ
            CLASS: exe_d.core_op = OP_CLASS;
            MVXW: begin
                exe_d.core_op = OP_MOVE;
                exe_d.sel.rm  = RUP;
            end
            MVWX: begin
                exe_d.core_op = OP_MOVE;
                exe_d.op_mod  = 1'b1; // Int to float direction
                exe_d.sel.rm  = RUP;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            exe_q <= exe_d;
        end
    end

    a_legal_op: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_valid_i |-> req_i.op inside {SGNJ, SGNJN, SGNJX, MIN, MAX, CMP, CLASS, MVXW, MVWX});

endmodule

/* src/fpu_noncomp.sv */
`timescale 1ns/1ps

module fpu_noncomp import fpu_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  logic      exe_valid_i,
    input  fpu_exec_t exe_i,
    output logic      exe_ready_o,

    output logic      rsp_valid_o,
    output fpu_rsp_t  rsp_o,
    input  logic      rsp_ready_i
);

    typedef struct packed {
        logic [31:0] data;
        logic        nv;
    } lane_res_t;

    function automatic logic is_nan(logic [31:0] x);
        return (&x[30:23]) && (|x[22:0]);
    endfunction

    function automatic logic is_snan(logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    // Total order on non-NaN values, -0 below +0
    function automatic logic f_less(logic [31:0] a, logic [31:0] b);
        if (a[31] != b[31])
            return a[31];
        else if (a[31])
            return a[30:0] > b[30:0];
        else
            return a[30:0] < b[30:0];
    endfunction

    function automatic logic [9:0] classify(logic [31:0] x);
        logic exp_max;
        logic exp_zero;
        logic man_zero;
        exp_max  = &x[30:23];
        exp_zero = ~|x[30:23];
        man_zero = ~|x[22:0];
        if (exp_max && !man_zero)
            return x[22] ? 10'h200 : 10'h100; // Quiet / signaling NaN
        else if (exp_max)
            return x[31] ? 10'h001 : 10'h080;
        else if (exp_zero && man_zero)
            return x[31] ? 10'h008 : 10'h010;
        else if (exp_zero)
            return x[31] ? 10'h004 : 10'h020; // Subnormal
        else
            return x[31] ? 10'h002 : 10'h040;
    endfunction

    function automatic lane_res_t lane_exec(core_op_e op, frm_sel_u sel,
                                            logic [31:0] a, logic [31:0] b);
        logic      any_nan;
        logic      any_snan;
        logic      both_zero;
        logic      lt;
        logic      eq;
        lane_res_t r;
        any_nan   = is_nan(a) | is_nan(b);
        any_snan  = is_snan(a) | is_snan(b);
        both_zero = ~|{a[30:0], b[30:0]};
        lt        = f_less(a, b) && !both_zero;
        eq        = (a == b) || both_zero;
        r         = '0;
        case (op)
            OP_SGNJ: begin
                case (sel.code)
                    SEL_NEG: r.data = {~b[31], a[30:0]};
                    SEL_XOR: r.data = {a[31] ^ b[31], a[30:0]};
                    default: r.data = {b[31], a[30:0]};
                endcase
            end
            OP_MINMAX: begin
                r.nv = any_snan;
                if (is_nan(a) && is_nan(b))
                    r.data = CANON_NAN;
                else if (is_nan(a))
                    r.data = b;
                else if (is_nan(b))
                    r.data = a;
                else
                    r.data = ((sel.code == SEL_MAX) ^ f_less(a, b)) ? a : b;
            end
            OP_CMP: begin
                case (sel.code)
                    SEL_FEQ: begin
                        r.data = {31'b0, eq && !any_nan};
                        r.nv   = any_snan; // Quiet compare
                    end
                    SEL_FLT: begin
                        r.data = {31'b0, lt && !any_nan};
                        r.nv   = any_nan;
                    end
                    SEL_FLE: begin
                        r.data = {31'b0, (lt || eq) && !any_nan};
                        r.nv   = any_nan;
                    end
                    default: ;
                endcase
            end
            OP_CLASS: r.data = {22'b0, classify(a)};
            default:  r.data = a; // Moves, no NV in either direction
        endcase
        return r;
    endfunction

    fpu_rsp_t rsp_d;
    fpu_rsp_t rsp_q;
    logic     valid_q;

    assign exe_ready_o = !valid_q || rsp_ready_i;
    assign rsp_valid_o = valid_q;
    assign rsp_o       = rsp_q;

    always_comb begin
        lane_res_t res;
        rsp_d.tmask    = exe_i.tmask;
        rsp_d.rd       = exe_i.rd;
        rsp_d.wb       = exe_i.wb;
        rsp_d.warp_num = exe_i.warp_num;
        for (int i = 0; i < NUM_THREADS; i++) begin
            res = lane_exec(exe_i.core_op, exe_i.sel, exe_i.rs1_data[i], exe_i.rs2_data[i]);
            rsp_d.data[i] = exe_i.tmask[i] ? res.data : 32'b0;
            rsp_d.nv[i]   = exe_i.tmask[i] & res.nv;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (exe_ready_o) begin
            valid_q <= exe_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exe_valid_i && exe_ready_o) begin
            rsp_q <= rsp_d;
        end
    end

endmodule

/* src/fpu_result_fifo.sv */
`timescale 1ns/1ps

module fpu_result_fifo import fpu_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     push_valid_i,
    input  fpu_rsp_t push_i,
    output logic     push_ready_o,

    output logic     pop_valid_o,
    output fpu_rsp_t pop_o,
    input  logic     pop_ready_i
);

    fpu_rsp_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr;
    logic [FIFO_PTR_BITS-1:0] rd_ptr;
    logic [FIFO_CNT_BITS-1:0] count;
    logic                     push;
    logic                     pop;

    assign push_ready_o = count != FIFO_CNT_BITS'(FIFO_DEPTH);
    assign pop_valid_o  = count != '0;
    assign pop_o        = mem[rd_ptr];

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= push_i;
        end
    end

    // Pointers meet only when empty or full
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push |-> wr_ptr != rd_ptr || count == '0);

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop |-> wr_ptr != rd_ptr || count == FIFO_CNT_BITS'(FIFO_DEPTH));

endmodule

/* src/fpu_commit.sv */
`timescale 1ns/1ps

module fpu_commit import fpu_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     rsp_valid_i,
    input  fpu_rsp_t rsp_i,
    output logic     rsp_ready_o,

    output logic     commit_valid_o,
    output fpu_rsp_t commit_o,
    input  logic     commit_ready_i,

    output logic     csr_valid_o,
    output fpu_csr_t csr_o
);

    fpu_rsp_t rsp_q;
    logic     valid_q;

    assign rsp_ready_o    = !valid_q || commit_ready_i;
    assign commit_valid_o = valid_q;
    assign commit_o       = rsp_q;

    // Flag strobe rides on the commit transfer
    assign csr_valid_o     = valid_q && commit_ready_i;
    assign csr_o.warp_num  = rsp_q.warp_num;
    assign csr_o.fflags.nv = |(rsp_q.nv & rsp_q.tmask);
    assign csr_o.fflags.dz = 1'b0;
    assign csr_o.fflags.of = 1'b0;
    assign csr_o.fflags.uf = 1'b0;
    assign csr_o.fflags.nx = 1'b0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (rsp_ready_o) begin
            valid_q <= rsp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_valid_i && rsp_ready_o) begin
            rsp_q <= rsp_i;
        end
    end

    a_hold_stalled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        commit_valid_o && !commit_ready_i |=> commit_valid_o && $stable(commit_o));

endmodule

/* src/fpu_unit.sv */
`timescale 1ns/1ps

module fpu_unit import fpu_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     req_valid_i,
    input  fpu_req_t req_i,
    output logic     req_ready_o,

    output logic     commit_valid_o,
    output fpu_rsp_t commit_o,
    input  logic     commit_ready_i,

    output logic     csr_valid_o,
    output fpu_csr_t csr_o
);

    logic      exe_valid;
    fpu_exec_t exe;
    logic      exe_ready;
    logic      rsp_valid;
    fpu_rsp_t  rsp;
    logic      rsp_ready;
    logic      buf_valid;
    fpu_rsp_t  buf_rsp;
    logic      buf_ready;

    fpu_req_decode u_decode (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .exe_valid_o (exe_valid),
        .exe_o       (exe),
        .exe_ready_i (exe_ready)
    );

    fpu_noncomp u_noncomp (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .exe_valid_i (exe_valid),
        .exe_i       (exe),
        .exe_ready_o (exe_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .rsp_ready_i (rsp_ready)
    );

    fpu_result_fifo u_fifo (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_valid_i (rsp_valid),
        .push_i       (rsp),
        .push_ready_o (rsp_ready),
        .pop_valid_o  (buf_valid),
        .pop_o        (buf_rsp),
        .pop_ready_i  (buf_ready)
    );

    fpu_commit u_commit (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .rsp_valid_i    (buf_valid),
        .rsp_i          (buf_rsp),
        .rsp_ready_o    (buf_ready),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .commit_ready_i (commit_ready_i),
        .csr_valid_o    (csr_valid_o),
        .csr_o          (csr_o)
    );

endmodule

/* tests/fpu_unit_checker.sv */
`timescale 1ns/1ps

module fpu_unit_checker import fpu_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     req_valid_i,
    input  fpu_req_t req_i,
    input  logic     req_ready_i,
    input  logic     commit_valid_i,
    input  fpu_rsp_t commit_i,
    input  logic     commit_ready_i,
    input  logic     csr_valid_i,
    input  fpu_csr_t csr_i,
    output int       value_errs_o,
    output int       flag_errs_o,
    output int       proto_errs_o,
    output int       pending_o
);

    fpu_rsp_t exp_q[$];
    fpu_rsp_t held;
    logic     stalled = 1'b0;
    logic     reset_seen = 1'b0;
    int       value_errs = 0;
    int       flag_errs = 0;
    int       proto_errs = 0;
    int       pending = 0;

    assign value_errs_o = value_errs;
    assign flag_errs_o  = flag_errs;
    assign proto_errs_o = proto_errs;
    assign pending_o    = pending;

    function automatic bit nan_of(logic [31:0] x);
        return x[30:23] == 8'hFF && x[22:0] != 23'h0;
    endfunction

    function automatic bit snan_of(logic [31:0] x);
        return nan_of(x) && !x[22];
    endfunction

    // Unsigned key that sorts floats by value, -0 just below +0
    function automatic logic [31:0] order_key(logic [31:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic [9:0] class_of(logic [31:0] x);
        logic [9:0] c;
        c = '0;
        if (x[30:23] == 8'hFF) begin
            if (x[22:0] == 23'h0)
                c[x[31] ? 0 : 7] = 1'b1;
            else
                c[x[22] ? 9 : 8] = 1'b1;
        end else if (x[30:23] == 8'h00) begin
            if (x[22:0] == 23'h0)
                c[x[31] ? 3 : 4] = 1'b1;
            else
                c[x[31] ? 2 : 5] = 1'b1;
        end else begin
            c[x[31] ? 1 : 6] = 1'b1;
        end
        return c;
    endfunction

    function automatic void model_lane(fpu_op_e op, logic [2:0] sel, logic [31:0] a,
                                       logic [31:0] b, output logic [31:0] y,
                                       output logic nv);
        logic either_nan;
        logic both_zero;
        logic eq;
        logic lt;
        either_nan = nan_of(a) || nan_of(b);
        both_zero  = (a[30:0] | b[30:0]) == 31'h0;
        eq         = !either_nan && (a == b || both_zero);
        lt         = !either_nan && !both_zero && order_key(a) < order_key(b);
        y          = '0;
        nv         = 1'b0;
        case (op)
            SGNJ:  y = {b[31], a[30:0]};
            SGNJN: y = {~b[31], a[30:0]};
            SGNJX: y = {a[31] ^ b[31], a[30:0]};
            MIN, MAX: begin
                nv = snan_of(a) || snan_of(b);
                if (nan_of(a) && nan_of(b))
                    y = CANON_NAN;
                else if (nan_of(a))
                    y = b;
                else if (nan_of(b))
                    y = a;
                else if (op == MIN)
                    y = (order_key(a) <= order_key(b)) ? a : b;
                else
                    y = (order_key(a) >= order_key(b)) ? a : b;
            end
            CMP: begin
                if (sel == 3'd2) begin
                    y  = {31'h0, eq};
                    nv = snan_of(a) || snan_of(b);
                end else begin
                    y  = {31'h0, (sel == 3'd1) ? lt : (lt || eq)};
                    nv = either_nan;
                end
            end
            CLASS: y = {22'h0, class_of(a)};
            default: y = a; // Bit moves
        endcase
    endfunction

    function automatic fpu_rsp_t model_rsp(fpu_req_t r);
        fpu_rsp_t    e;
        logic [31:0] y;
        logic        nv;
        e          = '0;
        e.tmask    = r.tmask;
        e.rd       = r.rd;
        e.wb       = r.wb;
        e.warp_num = r.warp_num;
        for (int i = 0; i < NUM_THREADS; i++) begin
            model_lane(r.op, r.frm.code, r.rs1_data[i], r.rs2_data[i], y, nv);
            if (r.tmask[i]) begin
                e.data[i] = y;
                e.nv[i]   = nv;
            end
        end
        return e;
    endfunction

    function automatic bit values_match(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected 0x%08h, got 0x%08h", name, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    always @(posedge clk_i) begin
        fpu_rsp_t   e;
        logic [4:0] exp_flags;
        if (arst_n_i) begin
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (req_ready_i !== 1'b1 || commit_valid_i !== 1'b0 || csr_valid_i !== 1'b0) begin
                    $display("Outputs not idle after reset (req_ready %b, commit_valid %b, csr_valid %b)",
                             req_ready_i, commit_valid_i, csr_valid_i);
                    proto_errs++;
                end
            end
            if (req_valid_i && req_ready_i)
                exp_q.push_back(model_rsp(req_i));
            if (stalled && (commit_valid_i !== 1'b1 || commit_i !== held)) begin
                $display("Commit output dropped or changed while the consumer stalled");
                proto_errs++;
            end
            if (commit_valid_i && commit_ready_i) begin
                if (csr_valid_i !== 1'b1) begin
                    $display("CSR strobe missing on a commit transfer");
                    proto_errs++;
                end
                if (exp_q.size() == 0) begin
                    $display("Commit transfer with no outstanding request in the model");
                    proto_errs++;
                end else begin
                    e = exp_q.pop_front();
                    if (!values_match("commit_o.rd", e.rd, commit_i.rd))
                        value_errs++;
                    if (!values_match("commit_o.wb", e.wb, commit_i.wb))
                        value_errs++;
                    if (!values_match("commit_o.warp_num", e.warp_num, commit_i.warp_num))
                        value_errs++;
                    if (!values_match("commit_o.tmask", e.tmask, commit_i.tmask))
                        value_errs++;
                    if (!values_match("commit_o.nv", e.nv, commit_i.nv))
                        value_errs++;
                    for (int i = 0; i < NUM_THREADS; i++) begin
                        if (!values_match($sformatf("commit_o.data[%0d]", i), e.data[i],
                                          commit_i.data[i]))
                            value_errs++;
                    end
                    exp_flags = {|(e.nv & e.tmask), 4'b0000}; // Only NV can accrue here
                    if (!values_match("csr_o.fflags", exp_flags, csr_i.fflags))
                        flag_errs++;
                    if (!values_match("csr_o.warp_num", e.warp_num, csr_i.warp_num))
                        flag_errs++;
                end
            end else if (csr_valid_i !== 1'b0) begin
                $display("CSR strobe without a commit transfer");
                proto_errs++;
            end
            stalled = commit_valid_i && !commit_ready_i;
            held    = commit_i;
            pending = exp_q.size();
        end
    end

endmodule

/* tests/fpu_unit_tb.sv */
`timescale 1ns/1ps

module fpu_unit_tb import fpu_pkg::*; ();

    localparam int SEED           = 85420;
    localparam int NUM_REQS       = 400;
    localparam int ACCEPT_TIMEOUT = 200; // Cycles
    localparam int DRAIN_TIMEOUT  = 1000;

    logic     clk;
    logic     arst_n;
    logic     req_valid;
    fpu_req_t req;
    logic     req_ready;
    logic     commit_valid;
    fpu_rsp_t commit;
    logic     commit_ready;
    logic     csr_valid;
    fpu_csr_t csr;
    int       value_errs;
    int       flag_errs;
    int       proto_errs;
    int       pending;
    int       timeouts;

    fpu_unit dut_i (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .req_ready_o    (req_ready),
        .commit_valid_o (commit_valid),
        .commit_o       (commit),
        .commit_ready_i (commit_ready),
        .csr_valid_o    (csr_valid),
        .csr_o          (csr)
    );

    fpu_unit_checker u_checker (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .req_ready_i    (req_ready),
        .commit_valid_i (commit_valid),
        .commit_i       (commit),
        .commit_ready_i (commit_ready),
        .csr_valid_i    (csr_valid),
        .csr_i          (csr),
        .value_errs_o   (value_errs),
        .flag_errs_o    (flag_errs),
        .proto_errs_o   (proto_errs),
        .pending_o      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic rand_ready();
        return $urandom_range(0, 3) != 0;
    endfunction

    // Mostly special values, NaN and subnormal mantissas kept nonzero
    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        r = $urandom;
        if (r[21:0] == 22'h0)
            r[0] = 1'b1;
        case ($urandom_range(0, 8))
            0: return {r[31], 31'h0};
            1: return {r[31], 8'hFF, 23'h0};
            2: return {r[31], 8'hFF, 1'b1, r[21:0]};
            3: return {r[31], 8'hFF, 1'b0, r[21:0]};
            4: return {r[31], 8'h00, 1'b0, r[21:0]};
            5: return CANON_NAN;
            default: return r;
        endcase
    endfunction

    function automatic fpu_req_t rand_request();
        fpu_req_t r;
        r.op = fpu_op_e'($urandom_range(0, 8));
        if (r.op == CMP)
            r.frm.code = 3'($urandom_range(0, 2));
        else
            r.frm.code = 3'($urandom_range(0, 4));
        r.tmask = NUM_THREADS'($urandom);
        for (int i = 0; i < NUM_THREADS; i++) begin
            r.rs1_data[i] = rand_operand();
            r.rs2_data[i] = ($urandom_range(0, 5) == 0) ? r.rs1_data[i] : rand_operand();
        end
        r.rd       = RD_BITS'($urandom);
        r.wb       = 1'($urandom);
        r.warp_num = WARP_BITS'($urandom);
        return r;
    endfunction

    task automatic idle_cycle();
        @(negedge clk);
        req_valid    = 1'b0;
        commit_ready = rand_ready();
        @(posedge clk);
    endtask

    task automatic send_request(input fpu_req_t r);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        @(negedge clk);
        req_valid    = 1'b1;
        req          = r;
        commit_ready = rand_ready();
        while (!accepted && waited < ACCEPT_TIMEOUT) begin
            @(posedge clk);
            accepted = req_ready;
            waited++;
            if (!accepted) begin
                @(negedge clk);
                commit_ready = rand_ready();
            end
        end
        if (!accepted) begin
            $display("Timeout: request not accepted within %0d cycles", ACCEPT_TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b0;
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            commit_ready = rand_ready();
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("Timeout: %0d results still outstanding after drain", pending);
            timeouts++;
        end
    endtask

    initial begin
        int total;
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        commit_ready = 1'b0;
        timeouts     = 0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int n = 0; n < NUM_REQS && timeouts == 0; n++) begin
            if ($urandom_range(0, 7) == 0)
                idle_cycle();
            send_request(rand_request());
        end
        if (timeouts == 0)
            drain();
        total = value_errs + flag_errs + proto_errs + timeouts;
        $display("Errors: value %0d, flags %0d, protocol %0d, timeouts %0d",
                 value_errs, flag_errs, proto_errs, timeouts);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
src/fpu_pkg.sv
src/fpu_req_decode.sv
src/fpu_noncomp.sv
src/fpu_result_fifo.sv
src/fpu_commit.sv
src/fpu_unit.sv
tests/fpu_unit_checker.sv
tests/fpu_unit_tb.sv

/* Bender.yml */
package:
  name: fpu_unit

sources:
  - src/fpu_pkg.sv
  - src/fpu_req_decode.sv
  - src/fpu_noncomp.sv
  - src/fpu_result_fifo.sv
  - src/fpu_commit.sv
  - src/fpu_unit.sv
  - target: test
    files:
      - tests/fpu_unit_checker.sv
      - tests/fpu_unit_tb.sv
